// File: source/exu_pkg.sv
// execute stage definitions
package exu_pkg;

	// datapath width
	localparam int xlen = 32;

	// register values, immediates, results
	typedef logic [xlen-1:0] word_t;
	// pc and jump or branch targets
	typedef logic [xlen-1:0] addr_t;
	// raw instruction word
	typedef logic [31:0] inst_t;

	// alu operation code, 4-bit encoding
	typedef logic [3:0] alu_op_t;

	localparam alu_op_t alu_add    = 4'd0;
	localparam alu_op_t alu_sub    = 4'd1;
	localparam alu_op_t alu_sll    = 4'd2;
	localparam alu_op_t alu_slt    = 4'd3;
	localparam alu_op_t alu_sltu   = 4'd4;
	localparam alu_op_t alu_xor    = 4'd5;
	localparam alu_op_t alu_srl    = 4'd6;
	localparam alu_op_t alu_sra    = 4'd7;
	localparam alu_op_t alu_or     = 4'd8;
	localparam alu_op_t alu_and    = 4'd9;
	localparam alu_op_t alu_pass_b = 4'd10;
	// shifts by the low five bits of operand b
	localparam alu_op_t alu_srl5   = 4'd11;
	localparam alu_op_t alu_sll5   = 4'd12;
	localparam alu_op_t alu_sra5   = 4'd13;

	// instruction class seen by the result stage
	typedef logic [2:0] inst_class_t;

	localparam inst_class_t cls_alu     = 3'd0;
	localparam inst_class_t cls_lui     = 3'd1;
	localparam inst_class_t cls_auipc   = 3'd2;
	localparam inst_class_t cls_jal     = 3'd3;
	localparam inst_class_t cls_jalr    = 3'd4;
	localparam inst_class_t cls_branch  = 3'd5;
	localparam inst_class_t cls_illegal = 3'd6;

	// major opcodes, inst[6:0]
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;

endpackage

// File: source/alu_op_decode.sv
// rv32i execute decoder
`timescale 1ns/1ps

module alu_op_decode (
	input  exu_pkg::inst_t       inst,
	output exu_pkg::alu_op_t     alu_op,
	output logic                 sel_a_pc,
	output logic                 sel_b_imm,
	output exu_pkg::word_t       imm,
	output exu_pkg::inst_class_t inst_class,
	output logic [2:0]           funct3
);
	import exu_pkg::*;

	logic [6:0] opcode;
	logic [6:0] funct7;
	logic       funct7_ok;
	alu_op_t    arith_op;
	word_t      imm_i;
	word_t      imm_u;
	word_t      imm_j;
	word_t      imm_b;

	// instruction fields
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// immediate formats, all sign extended from bit 31
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

	// funct7 check, only sub and sra may set bit 5
	always_comb begin
		funct7_ok = 1'b1;
		if (opcode == op_reg) begin
			funct7_ok = (funct7 == 7'h00) ||
				((funct7 == 7'h20) && ((funct3 == 3'd0) || (funct3 == 3'd5)));
		end else if (opcode == op_imm) begin
			if (funct3 == 3'd1) begin
				funct7_ok = (funct7 == 7'h00);
			end else if (funct3 == 3'd5) begin
				funct7_ok = (funct7 == 7'h00) || (funct7 == 7'h20);
			end
		end
	end

	// funct3 to alu code, shared by register and immediate forms
	always_comb begin
		case (funct3)
			// addi has no subtract form
			3'd0: arith_op = ((opcode == op_reg) && funct7[5]) ? alu_sub : alu_add;
			3'd1: arith_op = alu_sll5;
			3'd2: arith_op = alu_slt;
			3'd3: arith_op = alu_sltu;
			3'd4: arith_op = alu_xor;
			3'd5: arith_op = funct7[5] ? alu_sra5 : alu_srl5;
			3'd6: arith_op = alu_or;
			default: arith_op = alu_and;
		endcase
	end

	// per-opcode operand selects, immediate and class
	always_comb begin
		alu_op     = alu_add;
		sel_a_pc   = 1'b0;
		sel_b_imm  = 1'b0;
		imm        = imm_i;
		inst_class = cls_illegal;
		case (opcode)
			op_reg: begin
				alu_op     = arith_op;
				inst_class = funct7_ok ? cls_alu : cls_illegal;
			end
			op_imm: begin
				alu_op     = arith_op;
				sel_b_imm  = 1'b1;
				inst_class = funct7_ok ? cls_alu : cls_illegal;
			end
			op_lui: begin
				alu_op     = alu_pass_b;
				sel_b_imm  = 1'b1;
				imm        = imm_u;
				inst_class = cls_lui;
			end
			op_auipc: begin
				sel_a_pc   = 1'b1;
				sel_b_imm  = 1'b1;
				imm        = imm_u;
				inst_class = cls_auipc;
			end
			// jal target is formed in the result stage
			op_jal: begin
				imm        = imm_j;
				inst_class = cls_jal;
			end
			// alu gives rs1 + imm as the jump target
			op_jalr: begin
				sel_b_imm  = 1'b1;
				inst_class = cls_jalr;
			end
			op_branch: begin
				imm        = imm_b;
				inst_class = cls_branch;
			end
			default: inst_class = cls_illegal;
		endcase
	end

endmodule

// File: source/alu.sv
// integer alu
`timescale 1ns/1ps

module alu (
	input  exu_pkg::word_t   rs1_val,
	input  exu_pkg::word_t   rs2_val,
	input  exu_pkg::word_t   pc,
	input  exu_pkg::word_t   imm,
	input  logic             sel_a_pc,
	input  logic             sel_b_imm,
	input  exu_pkg::alu_op_t alu_op,
	output exu_pkg::word_t   alu_result
);
	import exu_pkg::*;

	word_t       op_a;
	word_t       op_b;
	logic [4:0]  shamt;
	logic [xlen:0] diff_u;
	logic [xlen:0] diff_s;
	logic        lt_u;
	logic        lt_s;

	// operand muxes
	assign op_a = sel_a_pc ? pc : rs1_val;
	assign op_b = sel_b_imm ? imm : rs2_val;

	// short shift amount
	assign shamt = op_b[4:0];

	// zero extended subtraction, bit 32 is the borrow
	assign diff_u = {1'b0, op_a} - {1'b0, op_b};
	// sign extended subtraction, bit 32 is the true sign
	assign diff_s = {op_a[xlen-1], op_a} - {op_b[xlen-1], op_b};

	assign lt_u = diff_u[xlen];
	assign lt_s = diff_s[xlen];

	always_comb begin
		case (alu_op)
			alu_add: begin
				alu_result = op_a + op_b;
			end
			alu_sub: begin
				alu_result = diff_u[xlen-1:0];
			end
			// full-width shift amount
			alu_sll: begin
				alu_result = op_a << op_b;
			end
			alu_slt: begin
				alu_result = {{(xlen-1){1'b0}}, lt_s};
			end
			alu_sltu: begin
				alu_result = {{(xlen-1){1'b0}}, lt_u};
			end
			alu_xor: begin
				alu_result = op_a ^ op_b;
			end
			alu_srl: begin
				alu_result = op_a >> op_b;
			end
			alu_sra: begin
				alu_result = word_t'($signed(op_a) >>> op_b);
			end
			alu_or: begin
				alu_result = op_a | op_b;
			end
			alu_and: begin
				alu_result = op_a & op_b;
			end
			// lui path, immediate straight through
			alu_pass_b: begin
				alu_result = op_b;
			end
			// rv32i shifts, low five bits only
			alu_srl5: begin
				alu_result = op_a >> shamt;
			end
			alu_sll5: begin
				alu_result = op_a << shamt;
			end
			alu_sra5: begin
				alu_result = word_t'($signed(op_a) >>> shamt);
			end
			default: begin
				alu_result = '0;
			end
		endcase
	end

	// decoder must never hand over an undefined code
	always_comb begin
		if (!$isunknown(alu_op)) begin
			assert (alu_op <= alu_sra5)
			else $error("alu: undefined operation code %0d", alu_op);
		end
	end

endmodule

// File: source/branch_compare.sv
// branch condition unit
`timescale 1ns/1ps

module branch_compare (
	input  exu_pkg::word_t rs1_val,
	input  exu_pkg::word_t rs2_val,
	input  logic [2:0]     funct3,
	output logic           taken
);

	logic eq;
	logic lt_s;
	logic lt_u;

	// comparisons kept apart from the alu so both run in parallel
	assign eq   = (rs1_val == rs2_val);
	assign lt_s = ($signed(rs1_val) < $signed(rs2_val));
	assign lt_u = (rs1_val < rs2_val);

	// condition picked by funct3
	always_comb begin
		case (funct3)
			// beq
			3'd0: begin
				taken = eq;
			end
			// bne
			3'd1: begin
				taken = !eq;
			end
			// blt
			3'd4: begin
				taken = lt_s;
			end
			// bge
			3'd5: begin
				taken = !lt_s;
			end
			// bltu
			3'd6: begin
				taken = lt_u;
			end
			// bgeu
			3'd7: begin
				taken = !lt_u;
			end
			// 2 and 3 are not branch conditions
			default: begin
				taken = 1'b0;
			end
		endcase
	end

endmodule

// File: source/exu_result_select.sv
// execute result stage
`timescale 1ns/1ps

module exu_result_select (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 in_valid,
	input  exu_pkg::addr_t       pc,
	input  exu_pkg::word_t       imm,
	input  exu_pkg::word_t       alu_result,
	input  exu_pkg::inst_class_t inst_class,
	input  logic                 taken,
	input  logic [4:0]           rd_in,
	output logic                 out_valid,
	output logic                 rd_wen,
	output logic                 branch_taken,
	output logic                 illegal,
	output logic [4:0]           rd_addr,
	output exu_pkg::word_t       rd_val,
	output exu_pkg::addr_t       next_pc
);
	import exu_pkg::*;

	addr_t pc_plus4;
	addr_t pc_target;
	addr_t next_pc_nxt;
	word_t rd_val_nxt;
	logic  is_jump;
	logic  is_branch;
	logic  legal;
	logic  wen_nxt;
	logic  taken_nxt;

	assign pc_plus4  = pc + 32'd4;
	// branch and jal target
	assign pc_target = pc + imm;

	assign is_jump   = (inst_class == cls_jal) || (inst_class == cls_jalr);
	assign is_branch = (inst_class == cls_branch);
	assign legal     = (inst_class != cls_illegal);

	// comparator result only matters for a branch
	assign taken_nxt = is_branch && taken;
	// x0 is never written
	assign wen_nxt   = legal && !is_branch && (rd_in != 5'd0);

	// jumps write the link address
	assign rd_val_nxt = is_jump ? pc_plus4 : alu_result;

	always_comb begin
		next_pc_nxt = pc_plus4;
		if (taken_nxt || (inst_class == cls_jal)) begin
			next_pc_nxt = pc_target;
		end else if (inst_class == cls_jalr) begin
			// jalr clears the low bit of rs1 + imm
			next_pc_nxt = {alu_result[xlen-1:1], 1'b0};
		end
	end

	// control flags pulse for one cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid    <= 1'b0;
			rd_wen       <= 1'b0;
			branch_taken <= 1'b0;
			illegal      <= 1'b0;
		end else begin
			out_valid    <= in_valid;
			rd_wen       <= in_valid && wen_nxt;
			branch_taken <= in_valid && taken_nxt;
			illegal      <= in_valid && !legal;
		end
	end

	// payload holds its value while idle
	always_ff @(posedge clk) begin
		if (in_valid) begin
			rd_addr <= rd_in;
			rd_val  <= rd_val_nxt;
			next_pc <= next_pc_nxt;
		end
	end

	// an undefined class would pass as legal and reach the register file
	assert property (@(posedge clk) disable iff (!arst_n)
		in_valid |-> (inst_class <= cls_illegal))
	else $error("result stage: undefined instruction class %0d", inst_class);

endmodule

// File: source/exu_top.sv
// rv32i execute stage
`timescale 1ns/1ps

module exu_top (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           in_valid,
	input  exu_pkg::inst_t inst,
	input  exu_pkg::addr_t pc,
	input  exu_pkg::word_t rs1_val,
	input  exu_pkg::word_t rs2_val,
	output logic           out_valid,
	output logic           rd_wen,
	output logic [4:0]     rd_addr,
	output exu_pkg::word_t rd_val,
	output exu_pkg::addr_t next_pc,
	output logic           branch_taken,
	output logic           illegal
);
	import exu_pkg::*;

	alu_op_t     alu_op;
	logic        sel_a_pc;
	logic        sel_b_imm;
	word_t       imm;
	inst_class_t inst_class;
	logic [2:0]  funct3;
	word_t       alu_result;
	logic        taken;

	// decode, combinational
	alu_op_decode u_decode (
		.inst       (inst),
		.alu_op     (alu_op),
		.sel_a_pc   (sel_a_pc),
		.sel_b_imm  (sel_b_imm),
		.imm        (imm),
		.inst_class (inst_class),
		.funct3     (funct3)
	);

	// alu and comparator side by side
	alu u_alu (
		.rs1_val    (rs1_val),
		.rs2_val    (rs2_val),
		.pc         (pc),
		.imm        (imm),
		.sel_a_pc   (sel_a_pc),
		.sel_b_imm  (sel_b_imm),
		.alu_op     (alu_op),
		.alu_result (alu_result)
	);

	branch_compare u_branch (
		.rs1_val (rs1_val),
		.rs2_val (rs2_val),
		.funct3  (funct3),
		.taken   (taken)
	);

	// single register stage, rd field rides along
	exu_result_select u_result (
		.clk          (clk),
		.arst_n       (arst_n),
		.in_valid     (in_valid),
		.pc           (pc),
		.imm          (imm),
		.alu_result   (alu_result),
		.inst_class   (inst_class),
		.taken        (taken),
		.rd_in        (inst[11:7]),
		.out_valid    (out_valid),
		.rd_wen       (rd_wen),
		.branch_taken (branch_taken),
		.illegal      (illegal),
		.rd_addr      (rd_addr),
		.rd_val       (rd_val),
		.next_pc      (next_pc)
	);

endmodule

// File: include/exu_ref_model.svh
// execute stage reference model
`ifndef EXU_REF_MODEL_SVH
`define EXU_REF_MODEL_SVH

// rv32i arithmetic selected by funct3, alt picks sub or sra
function automatic exu_pkg::word_t ref_arith(input logic [2:0] f3, input logic alt,
		input exu_pkg::word_t a, input exu_pkg::word_t b);
	case (f3)
		3'd0: return alt ? (a - b) : (a + b);
		3'd1: return a << b[4:0];
		3'd2: return {31'b0, ($signed(a) < $signed(b))};
		3'd3: return {31'b0, (a < b)};
		3'd4: return a ^ b;
		3'd5: begin
			if (alt) begin
				return exu_pkg::word_t'($signed(a) >>> b[4:0]);
			end
			return a >> b[4:0];
		end
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

// branch condition, funct3 2 and 3 never taken
function automatic logic ref_branch(input logic [2:0] f3,
		input exu_pkg::word_t a, input exu_pkg::word_t b);
	case (f3)
		3'd0: return a == b;
		3'd1: return a != b;
		3'd4: return $signed(a) < $signed(b);
		3'd5: return $signed(a) >= $signed(b);
		3'd6: return a < b;
		3'd7: return a >= b;
		default: return 1'b0;
	endcase
endfunction

// expected outputs of one instruction
function automatic void exu_ref(input exu_pkg::inst_t inst, input exu_pkg::addr_t pc,
		input exu_pkg::word_t rs1, input exu_pkg::word_t rs2,
		output logic wen, output exu_pkg::word_t val, output exu_pkg::addr_t npc,
		output logic taken, output logic illegal);
	logic [6:0]     f7;
	logic [2:0]     f3;
	logic           ok;
	logic           is_br;
	exu_pkg::word_t imm_i;
	exu_pkg::word_t imm_u;
	exu_pkg::word_t imm_j;
	exu_pkg::word_t imm_b;

	f7    = inst[31:25];
	f3    = inst[14:12];
	imm_i = {{20{inst[31]}}, inst[31:20]};
	imm_u = {inst[31:12], 12'b0};
	imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	ok    = 1'b1;
	is_br = 1'b0;
	taken = 1'b0;
	val   = '0;
	npc   = pc + 32'd4;
	case (inst[6:0])
		exu_pkg::op_reg: begin
			ok  = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
			val = ref_arith(f3, f7[5], rs1, rs2);
		end
		exu_pkg::op_imm: begin
			if (f3 == 3'd1) begin
				ok = (f7 == 7'h00);
			end else if (f3 == 3'd5) begin
				ok = (f7 == 7'h00) || (f7 == 7'h20);
			end
			val = ref_arith(f3, (f3 == 3'd5) && f7[5], rs1, imm_i);
		end
		exu_pkg::op_lui: val = imm_u;
		exu_pkg::op_auipc: val = pc + imm_u;
		exu_pkg::op_jal: begin
			val = pc + 32'd4;
			npc = pc + imm_j;
		end
		exu_pkg::op_jalr: begin
			val = pc + 32'd4;
			npc = (rs1 + imm_i) & ~32'd1;
		end
		exu_pkg::op_branch: begin
			is_br = 1'b1;
			taken = ref_branch(f3, rs1, rs2);
			npc   = taken ? (pc + imm_b) : (pc + 32'd4);
		end
		default: ok = 1'b0;
	endcase
	if (!ok) begin
		npc = pc + 32'd4;
	end
	illegal = !ok;
	wen     = ok && !is_br && (inst[11:7] != 5'd0);
endfunction

`endif

// File: sim/exu_tb.sv
// execute stage testbench
`timescale 1ns/1ps

module exu_tb;
	import exu_pkg::*;

	`include "exu_ref_model.svh"

	localparam int num_instr      = 2000;
	localparam int reset_cycles   = 10;
	localparam int timeout_cycles = 2 * num_instr + reset_cycles;

	logic  clk;
	logic  arst_n;
	logic  in_valid;
	inst_t inst;
	addr_t pc;
	word_t rs1_val;
	word_t rs2_val;

	logic       out_valid;
	logic       rd_wen;
	logic [4:0] rd_addr;
	word_t      rd_val;
	addr_t      next_pc;
	logic       branch_taken;
	logic       illegal;

	int seed;
	int error_count;
	int cycle_count = 0;

	// expected outputs, one entry per clock, idle cycles included
	string       q_name[$];
	logic        q_valid[$];
	logic        q_wen[$];
	logic        q_taken[$];
	logic        q_illegal[$];
	logic        q_chk_val[$];
	logic [4:0]  q_rd[$];
	word_t       q_val[$];
	addr_t       q_npc[$];

	exu_top UUT (
		.clk          (clk),
		.arst_n       (arst_n),
		.in_valid     (in_valid),
		.inst         (inst),
		.pc           (pc),
		.rs1_val      (rs1_val),
		.rs2_val      (rs2_val),
		.out_valid    (out_valid),
		.rd_wen       (rd_wen),
		.rd_addr      (rd_addr),
		.rd_val       (rd_val),
		.next_pc      (next_pc),
		.branch_taken (branch_taken),
		.illegal      (illegal)
	);

	always #5 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("Simulation FAILED");
			$fatal(1, "run aborted");
		end
	end

	task automatic check_value(input string test, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("MISMATCH %s %s expected %h actual %h", test, field, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	// all control flags low, as after reset
	task automatic check_flags_low(input string test);
		check_value(test, "out_valid", 32'(1'b0), 32'(out_valid));
		check_value(test, "rd_wen", 32'(1'b0), 32'(rd_wen));
		check_value(test, "branch_taken", 32'(1'b0), 32'(branch_taken));
		check_value(test, "illegal", 32'(1'b0), 32'(illegal));
	endtask

	task automatic push_expected(input string name, input logic v, input logic wen,
			input word_t val, input addr_t npc, input logic taken, input logic ill,
			input logic [4:0] rd, input logic chk_val);
		q_name.push_back(name);
		q_valid.push_back(v);
		q_wen.push_back(wen);
		q_val.push_back(val);
		q_npc.push_back(npc);
		q_taken.push_back(taken);
		q_illegal.push_back(ill);
		q_rd.push_back(rd);
		q_chk_val.push_back(chk_val);
	endtask

	// the oldest entry was captured at the last rising edge
	task automatic check_oldest();
		string      name;
		logic       v;
		logic       chk_val;
		logic [4:0] rd;
		word_t      val;
		addr_t      npc;
		if (q_valid.size() < 2) begin
			return;
		end
		name    = q_name.pop_front();
		v       = q_valid.pop_front();
		rd      = q_rd.pop_front();
		val     = q_val.pop_front();
		npc     = q_npc.pop_front();
		chk_val = q_chk_val.pop_front();
		check_value(name, "out_valid", 32'(v), 32'(out_valid));
		check_value(name, "rd_wen", 32'(q_wen.pop_front()), 32'(rd_wen));
		check_value(name, "branch_taken", 32'(q_taken.pop_front()), 32'(branch_taken));
		check_value(name, "illegal", 32'(q_illegal.pop_front()), 32'(illegal));
		if (v) begin
			check_value(name, "next_pc", npc, next_pc);
			check_value(name, "rd_addr", 32'(rd), 32'(rd_addr));
			// rd_val only carries meaning for legal writing classes
			if (chk_val) begin
				check_value(name, "rd_val", val, rd_val);
			end
		end
	endtask

	// one instruction from the legal encodings of a random class
	task automatic gen_inst(output inst_t inst_v, output string name);
		logic [31:0] r;
		logic [31:0] body;
		logic [2:0]  f3;
		logic [6:0]  f7;
		r    = $random(seed);
		body = $random(seed);
		f3   = r[6:4];
		// sub and sra are the only alternate forms
		f7   = (((f3 == 3'd0) || (f3 == 3'd5)) && r[8]) ? 7'h20 : 7'h00;
		case (r[3:0])
			4'd0, 4'd1, 4'd2: begin
				inst_v = {f7, body[24:15], f3, body[11:7], op_reg};
				name   = "reg";
			end
			4'd3, 4'd4, 4'd5: begin
				if ((f3 == 3'd1) || (f3 == 3'd5)) begin
					inst_v = {f7, body[24:15], f3, body[11:7], op_imm};
				end else begin
					inst_v = {body[31:15], f3, body[11:7], op_imm};
				end
				name = "imm";
			end
			4'd6: begin
				inst_v = {body[31:7], op_lui};
				name   = "lui";
			end
			4'd7: begin
				inst_v = {body[31:7], op_auipc};
				name   = "auipc";
			end
			4'd8: begin
				inst_v = {body[31:7], op_jal};
				name   = "jal";
			end
			4'd9: begin
				inst_v = {body[31:15], 3'd0, body[11:7], op_jalr};
				name   = "jalr";
			end
			4'd10, 4'd11, 4'd12: begin
				// mostly the six real conditions, now and then code 2 or 3
				if ((f3[2:1] == 2'b01) && r[9]) begin
					f3[2] = 1'b1;
				end
				inst_v = {body[31:15], f3, body[11:7], op_branch};
				name   = "branch";
			end
			4'd13: begin
				inst_v = {body[31:25] | 7'h40, body[24:15], f3, body[11:7], op_reg};
				name   = "bad_funct7";
			end
			default: begin
				inst_v = body;
				name   = "random";
			end
		endcase
	endtask

	initial begin
		inst_t       inst_v;
		addr_t       pc_v;
		word_t       rs1_v;
		word_t       rs2_v;
		logic [31:0] r;
		string       name;
		logic        v;
		logic        m_wen;
		logic        m_taken;
		logic        m_illegal;
		logic        chk_val;
		word_t       m_val;
		addr_t       m_npc;
		int          sent;
		seed        = 32'h8eeef4c2;
		error_count = 0;
		sent        = 0;
		clk         = 1'b0;
		arst_n      = 1'b0;
		in_valid    = 1'b0;
		inst        = '0;
		pc          = '0;
		rs1_val     = '0;
		rs2_val     = '0;

		repeat (reset_cycles) begin
			@(negedge clk);
			check_flags_low("reset");
		end
		@(posedge clk);
		arst_n <= 1'b1;
		// first cycle after reset must stay quiet
		push_expected("after_reset", 1'b0, 1'b0, '0, '0, 1'b0, 1'b0, 5'd0, 1'b0);

		while (sent < num_instr) begin
			@(posedge clk);
			gen_inst(inst_v, name);
			r     = $random(seed);
			rs1_v = $random(seed);
			rs2_v = $random(seed);
			pc_v  = $random(seed);
			pc_v  = {pc_v[31:2], 2'b00};
			// equal operands for the branch conditions
			if (r[3:2] == 2'b00) begin
				rs2_v = rs1_v;
			end
			// about three cycles in four carry an instruction
			v = (r[1:0] != 2'b00);
			inst     <= inst_v;
			pc       <= pc_v;
			rs1_val  <= rs1_v;
			rs2_val  <= rs2_v;
			in_valid <= v;
			if (v) begin
				exu_ref(inst_v, pc_v, rs1_v, rs2_v, m_wen, m_val, m_npc, m_taken, m_illegal);
				chk_val = !m_illegal && (inst_v[6:0] != op_branch);
				push_expected(name, 1'b1, m_wen, m_val, m_npc, m_taken, m_illegal,
					inst_v[11:7], chk_val);
				sent++;
			end else begin
				push_expected("idle", 1'b0, 1'b0, '0, '0, 1'b0, 1'b0, 5'd0, 1'b0);
			end
			@(negedge clk);
			check_oldest();
		end

		// drain the last instruction
		@(posedge clk);
		in_valid <= 1'b0;
		push_expected("idle", 1'b0, 1'b0, '0, '0, 1'b0, 1'b0, 5'd0, 1'b0);
		@(negedge clk);
		check_oldest();

		if (error_count == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("Simulation FAILED");
			$fatal(1, "errors found");
		end
	end

endmodule

// File: src.f
+incdir+include
source/exu_pkg.sv
source/alu_op_decode.sv
source/alu.sv
source/branch_compare.sv
source/exu_result_select.sv
source/exu_top.sv
sim/exu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module exu_tb -f src.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vexu_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "^Simulation PASSED$"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
